//--- cpu8_sys.f
cpu8_pkg.sv
cpu8_mem_if.sv
cpu8_alu.sv
cpu8_core.sv
cpu8_mem.sv
cpu8_sys.sv
cpu8_tb_chk.sv
cpu8_tb.sv

//--- run.sh
#!/bin/sh
# build the cpu8 testbench with Verilator and run it
# a failure line in the log, or a missing pass line, fails the run
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module cpu8_tb -f cpu8_sys.f -o cpu8_sim \
  && ./obj_dir/cpu8_sim > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -q "Regression failed" sim.log && exit 1 \
  ; grep -q "Regression passed" sim.log || exit 1
exit 0

//--- cpu8_tb.sv
/*
  directed tests for the cpu8 system, programs are built in an image and loaded in reset
  every test compares all 256 memory words with a reference image
  sp is 0 after reset, so the stack grows down from 0xff
  data results live at 0x80 and up, programs stay below that
*/
`timescale 1ns/1ns

module cpu8_tb import cpu8_pkg::*; ();

  localparam int clk_period    = 4;
  localparam int per_instr     = 3 * (mem_wait + 2) + 2;  // fetch, imm, exec, write_mem
  localparam int instr_total   = 31 + 17 + 10 + 15 + 5;   // alu, cmp, jumps, stack, load
  localparam int test_overhead = 640;                     // reset, load, hold, peeks
  localparam int limit_cycles  = instr_total * per_instr + 5 * test_overhead;

  // operation field of a 2-register instr
  localparam logic [2:0] op_mov = 3'd0;
  localparam logic [2:0] op_add = 3'd1;
  localparam logic [2:0] op_sub = 3'd2;
  localparam logic [2:0] op_shl = 3'd3;
  localparam logic [2:0] op_shr = 3'd4;
  localparam logic [2:0] op_cmp = 3'd5;
  localparam logic [2:0] op_and = 3'd6;
  localparam logic [2:0] op_or  = 3'd7;

  logic  in_clk;
  logic  in_rst;
  logic  load_en;
  addr_t load_addr;
  word_t load_data;
  addr_t peek_addr;
  word_t peek_data;
  logic  halted;
  word_t instr;

  word_t img [256];       // image sent through the loader
  word_t ref_mem [256];   // memory expected after the run
  int    wp;              // next free image word
  int    errors;
  int    checks;
  logic [31:0] seed = 32'h90ee_4360;

  cpu8_sys uut (
    .in_clk    (in_clk),
    .in_rst    (in_rst),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .peek_addr (peek_addr),
    .peek_data (peek_data),
    .halted    (halted),
    .instr     (instr)
  );

  initial begin
    in_clk = 1'b0;
    forever #(clk_period / 2) in_clk = ~in_clk;
  end

  // watchdog, sized from the instruction count of all tests
  initial begin
    #(limit_cycles * clk_period);
    $display("timeout, a program did not halt within %0d cycles", limit_cycles);
    $display("Regression failed");
    $finish;
  end

  // --------------------------------------
  // helpers
  function automatic word_t next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed[31:24];   // upper bits
  endfunction

  function automatic word_t fill_value(input int a);
    word_t w;
    w = word_t'(a);
    return {w[3:0], w[7:4]} ^ 8'h3c;   // nibble swap, all address bits used
  endfunction

  // unsigned compare flags, eq ne lt le gt ge from bit 5 down
  function automatic word_t compare_flags(input word_t a, input word_t b);
    return {2'b00, a == b, a != b, a < b, a <= b, a > b, a >= b};
  endfunction

  task automatic check(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic new_program();
    for (int a = 0; a < 256; a++) begin
      img[a]     = fill_value(a);
      ref_mem[a] = fill_value(a);
    end
    wp = 0;
  endtask

  task automatic put(input word_t w);
    img[wp]     = w;
    ref_mem[wp] = w;   // program words stay as loaded
    wp++;
  endtask

  task automatic put_2reg(input logic [2:0] op, input int a, input int b);
    put({1'b1, op, 2'(a), 2'(b)});
  endtask

  task automatic put_1reg(input logic imm, input logic [2:0] code, input int r);
    put({2'b01, imm, code, 2'(r)});
  endtask

  task automatic put_ldi(input int r, input word_t v);
    put_1reg(1'b1, 3'd0, r);
    put(v);
  endtask

  task automatic put_ld(input int r, input word_t addr);
    put_1reg(1'b1, 3'd1, r);
    put(addr);
  endtask

  task automatic put_st(input int r, input word_t addr);
    put_1reg(1'b1, 3'd2, r);
    put(addr);
  endtask

  // r3 = r1 op r2, then stored
  task automatic alu_to_mem(input logic [2:0] op, input word_t addr);
    put_2reg(op_mov, 1, 3);
    put_2reg(op, 3, 2);
    put_st(3, addr);
  endtask

  // --------------------------------------
  // load in reset, run to halt, hold, compare memory
  task automatic run_program(input int hold);
    @(posedge in_clk);
    in_rst <= 1'b1;
    repeat (5) @(posedge in_clk);
    for (int a = 0; a < 256; a++) begin
      load_en   <= 1'b1;
      load_addr <= addr_t'(a);
      load_data <= img[a];
      @(posedge in_clk);
    end
    load_en <= 1'b0;
    in_rst  <= 1'b0;
    repeat (mem_wait + 2) @(posedge in_clk);   // first fetch lands
    @(negedge in_clk);
    check("instr", instr, img[entry_addr]);
    while (!halted) @(negedge in_clk);
    repeat (hold) begin
      @(negedge in_clk);
      check("halted", word_t'(halted), 8'h01);   // must stay up
      check("instr", instr, 8'h00);              // halt opcode held
    end
    for (int a = 0; a < 256; a++) begin
      @(posedge in_clk);
      peek_addr <= addr_t'(a);
      @(negedge in_clk);
      check($sformatf("mem[%02h]", a), peek_data, ref_mem[a]);
    end
  endtask

  // --------------------------------------
  // directed tests
  task automatic test_alu();
    word_t x;
    word_t y;
    word_t sh;
    x  = next_random();
    y  = next_random();
    sh = next_random() & 8'h07;   // shift amount 0..7
    new_program();
    put_ldi(1, x);
    put_ldi(2, y);
    alu_to_mem(op_add, 8'h80);
    alu_to_mem(op_sub, 8'h81);
    alu_to_mem(op_and, 8'h82);
    alu_to_mem(op_or, 8'h83);
    put_2reg(op_mov, 1, 3);
    put_1reg(1'b0, 3'd4, 3);      // bitwise not
    put_st(3, 8'h84);
    put_2reg(op_mov, 1, 3);
    put_1reg(1'b0, 3'd5, 3);      // logical not
    put_st(3, 8'h85);
    put_ldi(3, 8'h00);            // logical not of zero
    put_1reg(1'b0, 3'd5, 3);
    put_st(3, 8'h86);
    put_ldi(2, sh);
    alu_to_mem(op_shl, 8'h87);
    alu_to_mem(op_shr, 8'h88);
    put(8'h00);                   // halt
    ref_mem[8'h80] = x + y;
    ref_mem[8'h81] = x - y;
    ref_mem[8'h82] = x & y;
    ref_mem[8'h83] = x | y;
    ref_mem[8'h84] = ~x;
    ref_mem[8'h85] = (x == 8'h00) ? 8'h01 : 8'h00;
    ref_mem[8'h86] = 8'h01;
    ref_mem[8'h87] = x << sh;
    ref_mem[8'h88] = x >> sh;
    run_program(4);
  endtask

  task automatic test_compare();
    word_t a [4];
    word_t b [4];
    a[0] = next_random();
    b[0] = a[0];                  // equal pair
    a[1] = next_random();
    b[1] = next_random();
    a[2] = b[1];                  // same pair swapped
    b[2] = a[1];
    a[3] = next_random();
    b[3] = next_random();
    new_program();
    for (int k = 0; k < 4; k++) begin
      put_ldi(1, a[k]);
      put_ldi(2, b[k]);
      put_2reg(op_cmp, 1, 2);     // flags into r3
      put_st(3, word_t'(8'h90 + k));
      ref_mem[8'h90 + k] = compare_flags(a[k], b[k]);
    end
    put(8'h00);
    run_program(4);
  endtask

  task automatic test_jumps();
    word_t mark;
    int    fix;
    mark = next_random() | 8'h80;   // fill at a0 and a2 has bit 7 clear
    new_program();
    put_ldi(2, mark);
    fix = wp;
    put_ldi(1, 8'h00);              // target patched below
    put_1reg(1'b0, 3'd1, 1);        // jmp r1
    put_st(2, 8'ha0);               // skipped
    img[fix + 1]     = word_t'(wp);
    ref_mem[fix + 1] = word_t'(wp);
    put_st(2, 8'ha1);
    put_ldi(1, 8'h02);              // over one 2-word store
    put_1reg(1'b0, 3'd2, 1);        // jrel r1
    put_st(2, 8'ha2);               // skipped
    put_st(2, 8'ha3);
    put(8'h00);
    ref_mem[8'ha1] = mark;
    ref_mem[8'ha3] = mark;
    run_program(4);
  endtask

  task automatic test_stack();
    word_t x;
    word_t y;
    word_t c;
    int    fix;
    int    ret_addr;
    x = next_random();
    y = next_random();
    c = next_random();
    new_program();
    put_ldi(1, x);
    put_ldi(2, y);
    put_1reg(1'b0, 3'd6, 1);      // push r1 -> 0xff
    put_1reg(1'b0, 3'd6, 2);      // push r2 -> 0xfe
    put_1reg(1'b0, 3'd7, 1);      // pop, r1 gets y
    put_1reg(1'b0, 3'd7, 2);      // pop, r2 gets x
    put_st(1, 8'hb0);
    put_st(2, 8'hb1);
    fix = wp;
    put_ldi(1, 8'h00);            // subroutine address, patched
    put_1reg(1'b0, 3'd3, 1);      // call r1
    ret_addr = wp;
    put_st(0, 8'hb2);             // sp after return
    put(8'h00);
    img[fix + 1]     = word_t'(wp);
    ref_mem[fix + 1] = word_t'(wp);
    put_ldi(2, c);                // subroutine body
    put_st(2, 8'hb3);
    put(8'h02);                   // ret
    ref_mem[8'hb0] = y;
    ref_mem[8'hb1] = x;
    ref_mem[8'hb2] = 8'h00;       // sp back at its reset value
    ref_mem[8'hb3] = c;
    ref_mem[8'hfe] = y;
    ref_mem[8'hff] = word_t'(ret_addr);   // call pushed over the first push
    run_program(4);
  endtask

  task automatic test_load_halt();
    word_t v;
    word_t k;
    v = next_random();
    k = next_random();
    new_program();
    img[8'hc0]     = v;           // preloaded data word
    ref_mem[8'hc0] = v;
    put_ld(1, 8'hc0);
    put_ldi(2, k);
    put_2reg(op_add, 1, 2);
    put_st(1, 8'hc0);
    put(8'h00);
    ref_mem[8'hc0] = v + k;
    run_program(40);              // long hold after halt
  endtask

  // --------------------------------------
  initial begin
    in_rst    = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    peek_addr = '0;
    errors    = 0;
    checks    = 0;
    repeat (5) @(posedge in_clk);
    test_alu();
    test_compare();
    test_jumps();
    test_stack();
    test_load_halt();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- cpu8_tb_chk.sv
/*
  memory bus checks, bound into the system top where bus and halted meet
  all assertions are off while in_rst is high
*/
`timescale 1ns/1ns

module cpu8_tb_chk import cpu8_pkg::*; (
  input logic in_clk,
  input logic in_rst,
  input logic req,
  input logic ready,
  input logic halted
);

  logic pending;   // transfer in flight

  always_ff @(posedge in_clk) begin
    if (in_rst)
      pending <= 1'b0;
    else if (req)
      pending <= 1'b1;
    else if (ready)
      pending <= 1'b0;
  end

  // --------------------------------------
  a_ready_after_req: assert property (
    @(posedge in_clk) disable iff (in_rst) req |-> ##mem_wait ready
  ) else $error("ready missing %0d cycles after req", mem_wait);

  a_ready_has_req: assert property (
    @(posedge in_clk) disable iff (in_rst) ready |-> $past(req, mem_wait)
  ) else $error("ready without a matching req");

  a_one_in_flight: assert property (
    @(posedge in_clk) disable iff (in_rst) pending |-> !req
  ) else $error("req while a transfer is outstanding");

  a_quiet_halt: assert property (
    @(posedge in_clk) disable iff (in_rst) halted |-> !req
  ) else $error("req after halt");

endmodule

bind cpu8_sys cpu8_tb_chk bus_chk (
  .in_clk (mem_bus.in_clk),
  .in_rst (mem_bus.in_rst),
  .req    (mem_bus.req),
  .ready  (mem_bus.ready),
  .halted (halted)
);

//--- cpu8_sys.sv
/*
  core and memory joined by the memory bus
  load port only takes writes while in_rst is high
  peek reads the array combinationally, halted marks program end
*/
`timescale 1ns/1ns

module cpu8_sys import cpu8_pkg::*; (
  input  logic  in_clk,
  input  logic  in_rst,
  input  logic  load_en,     // program loader
  input  addr_t load_addr,
  input  word_t load_data,
  input  addr_t peek_addr,   // memory readback
  output word_t peek_data,
  output logic  halted,
  output word_t instr        // current opcode
);

  cpu8_mem_if mem_bus (.in_clk(in_clk), .in_rst(in_rst));

  cpu8_core core (
    .in_clk (in_clk),
    .in_rst (in_rst),
    .mem    (mem_bus.core),
    .halted (halted),
    .instr  (instr)
  );

  cpu8_mem ram (
    .in_clk    (in_clk),
    .in_rst    (in_rst),
    .mem       (mem_bus.mem),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .peek_addr (peek_addr),
    .peek_data (peek_data)
  );

endmodule

//--- cpu8_mem.sv
/*
  256-word program and data memory, fixed latency of mem_wait cycles
  a req while busy is dropped; load port writes only while in_rst is high
  array has no reset, a loaded program survives reset
*/
`timescale 1ns/1ns

module cpu8_mem import cpu8_pkg::*; (
  input  logic    in_clk,
  input  logic    in_rst,
  cpu8_mem_if.mem mem,
  input  logic    load_en,
  input  addr_t   load_addr,
  input  word_t   load_data,
  input  addr_t   peek_addr,
  output word_t   peek_data
);

  typedef logic [$clog2(mem_wait + 1)-1:0] wait_t;

  word_t arr [2**addr_bits];
  logic  busy;        // one transfer pending
  wait_t wait_cnt;    // cycles left until fire
  logic  fire;        // transfer happens this edge
  logic  ready_q;
  word_t rdata_q;
  addr_t lat_addr;    // request latched with req
  logic  lat_write;
  word_t lat_wdata;

  assign fire      = busy && (wait_cnt == wait_t'(1));
  assign mem.ready = ready_q;
  assign mem.rdata = rdata_q;
  assign peek_data = arr[peek_addr];   // combinational peek

  // --------------------------------------
  // wait counter and ready pulse
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      busy     <= 1'b0;
      wait_cnt <= '0;
      ready_q  <= 1'b0;
    end else begin
      ready_q <= fire;                 // lands mem_wait after req
      if (fire) begin
        busy <= 1'b0;
      end else if (busy) begin
        wait_cnt <= wait_cnt - 1'b1;
      end else if (mem.req) begin
        busy     <= 1'b1;
        wait_cnt <= wait_t'(mem_wait - 1);
      end
    end
  end

  // request latch and read data
  always_ff @(posedge in_clk) begin
    if (mem.req && !busy) begin
      lat_addr  <= mem.addr;
      lat_write <= mem.write;
      lat_wdata <= mem.wdata;
    end
    if (fire)
      rdata_q <= arr[lat_addr];
  end

  // array writes: loader in reset, bus otherwise
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      if (load_en)
        arr[load_addr] <= load_data;
    end else if (fire && lat_write) begin
      arr[lat_addr] <= lat_wdata;
    end
  end

endmodule

//--- cpu8_core.sv
/*
  multi-cycle fetch/decode/execute controller, one memory transfer at a time
  registers clear on reset; sp starts at 0, so the first push lands at 0xff
  interrupts and the 0-register immediate opcode run as nop
  halt holds all state until the next reset
*/
`timescale 1ns/1ns

module cpu8_core import cpu8_pkg::*; (
  input  logic     in_clk,
  input  logic     in_rst,
  cpu8_mem_if.core mem,
  output logic     halted,
  output word_t    instr
);

  // --------------------------------------
  // state
  cycle_e cycle;
  logic   step;                   // 0 issues request, 1 waits ready
  addr_t  pc;
  word_t [num_regs-1:0] regs;
  word_t  immval;                 // word after the opcode
  reg_idx_t reg_a;
  reg_idx_t reg_b;
  logic   is_2reg;
  logic   is_1reg;
  logic   has_imm;
  alu_op_e alu_op;
  word_t  alu_result;

  // bus drivers, registered
  logic   mem_req;
  logic   mem_write;
  addr_t  mem_addr;
  word_t  mem_wdata;

  assign mem.req   = mem_req;
  assign mem.write = mem_write;
  assign mem.addr  = mem_addr;
  assign mem.wdata = mem_wdata;

  cpu8_alu alu (
    .op     (alu_op),
    .a      (regs[reg_a]),
    .b      (regs[reg_b]),
    .result (alu_result)
  );

  // --------------------------------------
  // controller
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      cycle     <= fetch;
      step      <= 1'b0;
      pc        <= addr_t'(entry_addr);
      regs      <= '0;
      instr     <= '0;
      is_2reg   <= 1'b0;
      is_1reg   <= 1'b0;
      has_imm   <= 1'b0;
      mem_req   <= 1'b0;
      mem_write <= 1'b0;
      halted    <= 1'b0;
    end else begin
      mem_req <= 1'b0;              // pulse only
      halted  <= (cycle == halt);
      case (cycle)
        fetch: begin
          if (!step) begin
            mem_addr <= pc;         // read opcode
            mem_req  <= 1'b1;
            pc       <= pc + 1'b1;
            step     <= 1'b1;
          end else if (mem.ready) begin
            instr <= mem.rdata;
            step  <= 1'b0;
            cycle <= decode;
          end
        end

        decode: begin
          is_2reg <= instr[7];
          is_1reg <= (instr[7:6] == 2'b01);
          has_imm <= (instr[7:5] == 3'b011);   // 0-reg imm form stays nop
          reg_a   <= instr[7] ? instr[3:2] : instr[1:0];
          reg_b   <= instr[1:0];
          if (instr[7])
            alu_op <= alu_op_e'({1'b0, instr[6:4]});
          else if (instr[4:2] == op1_not)
            alu_op <= not_bit;
          else if (instr[4:2] == op1_lnot)
            alu_op <= not_log;
          else
            alu_op <= mov;
          cycle <= (instr[7:5] == 3'b011) ? load_imm : exec;
        end

        load_imm: begin
          if (!step) begin
            mem_addr <= pc;
            mem_req  <= 1'b1;
            pc       <= pc + 1'b1;
            step     <= 1'b1;
          end else if (mem.ready) begin
            immval <= mem.rdata;
            step   <= 1'b0;
            cycle  <= exec;
          end
        end

        exec: begin
          cycle <= fetch;           // single-cycle default
          if (is_2reg) begin
            if (alu_op == mov)
              regs[reg_b] <= alu_result;       // a -> b
            else if (alu_op == cmp)
              regs[status_idx] <= alu_result;  // flags only
            else
              regs[reg_a] <= alu_result;
          end else if (is_1reg && has_imm) begin
            case (instr[4:2])
              op1_ldi: regs[reg_a] <= immval;
              op1_ld: begin
                cycle <= exec;
                if (!step) begin
                  mem_addr <= immval;
                  mem_req  <= 1'b1;
                  step     <= 1'b1;
                end else if (mem.ready) begin
                  regs[reg_a] <= mem.rdata;
                  step        <= 1'b0;
                  cycle       <= fetch;
                end
              end
              op1_st: begin
                mem_addr  <= immval;
                mem_wdata <= regs[reg_a];
                cycle     <= write_mem;
              end
              default: ;            // unused, nop
            endcase
          end else if (is_1reg) begin
            case (instr[4:2])
              op1_jmp:  pc <= regs[reg_a];
              op1_jrel: pc <= pc + regs[reg_a];   // pc already past instr
              op1_call: begin
                pc             <= regs[reg_a];
                regs[sp_idx]   <= regs[sp_idx] - 1'b1;
                mem_addr       <= regs[sp_idx] - 1'b1;
                mem_wdata      <= pc;             // return address
                cycle          <= write_mem;
              end
              op1_not, op1_lnot: regs[reg_a] <= alu_result;
              op1_push: begin
                regs[sp_idx] <= regs[sp_idx] - 1'b1;  // pre-decrement
                mem_addr     <= regs[sp_idx] - 1'b1;
                mem_wdata    <= regs[reg_a];
                cycle        <= write_mem;
              end
              op1_pop: begin
                cycle <= exec;
                if (!step) begin
                  regs[sp_idx] <= regs[sp_idx] + 1'b1;  // post-increment
                  mem_addr     <= regs[sp_idx];
                  mem_req      <= 1'b1;
                  step         <= 1'b1;
                end else if (mem.ready) begin
                  regs[reg_a] <= mem.rdata;
                  step        <= 1'b0;
                  cycle       <= fetch;
                end
              end
              default: ;            // 000 is nop
            endcase
          end else begin
            case (instr[5:0])
              op0_halt: cycle <= halt;
              op0_nop:  ;
              op0_ret: begin
                cycle <= exec;
                if (!step) begin
                  regs[sp_idx] <= regs[sp_idx] + 1'b1;
                  mem_addr     <= regs[sp_idx];
                  mem_req      <= 1'b1;
                  step         <= 1'b1;
                end else if (mem.ready) begin
                  pc    <= mem.rdata;
                  step  <= 1'b0;
                  cycle <= fetch;
                end
              end
              default: ;            // reti and the rest, nop
            endcase
          end
        end

        write_mem: begin
          if (!step) begin
            mem_req   <= 1'b1;      // addr and wdata set in exec
            mem_write <= 1'b1;
            step      <= 1'b1;
          end else if (mem.ready) begin
            mem_write <= 1'b0;
            step      <= 1'b0;
            cycle     <= fetch;
          end
        end

        halt: ;                     // wait for reset

        default: cycle <= fetch;
      endcase
    end
  end

endmodule

//--- cpu8_alu.sv
/*
  combinational data path, no state
  shift amount is the whole b operand, zero fill
  compare returns the packed status word, unsigned
*/
`timescale 1ns/1ns

module cpu8_alu import cpu8_pkg::*; (
  input  alu_op_e op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result
);

  word_t flags;  // compare result

  // --------------------------------------
  // status word
  always_comb begin
    flags        = '0;       // 7:6 stay zero
    flags[st_eq] = (a == b);
    flags[st_ne] = (a != b);
    flags[st_lt] = (a < b);
    flags[st_le] = (a <= b);
    flags[st_gt] = (a > b);
    flags[st_ge] = (a >= b);
  end

  // --------------------------------------
  // operation select
  always_comb begin
    case (op)
      mov:     result = a;       // core writes it to b's register
      add:     result = a + b;
      sub:     result = a - b;   // wraps
      shl:     result = a << b;  // b >= 8 gives 0
      shr:     result = a >> b;
      cmp:     result = flags;
      and_op:  result = a & b;
      or_op:   result = a | b;
      not_bit: result = ~a;
      not_log: begin
        // 1 for zero, else 0
        result = (a == '0) ? word_t'(1) : '0;
      end
      default: result = a;
    endcase
  end

endmodule

//--- cpu8_mem_if.sv
/*
  single-transfer memory bus, req is a one-cycle pulse
  ready answers mem_wait cycles later, rdata valid in that cycle
  clock and reset are carried for checkers bound into the bus
*/
`timescale 1ns/1ns

interface cpu8_mem_if import cpu8_pkg::*; (
  input logic in_clk,
  input logic in_rst
);

  logic  req;    // launches one transfer
  logic  write;  // 1 write, 0 read
  addr_t addr;   // sampled with req
  word_t wdata;  // sampled with req
  word_t rdata;  // valid with ready
  logic  ready;  // one-cycle answer

  modport core (output req, write, addr, wdata, input rdata, ready);
  modport mem (input req, write, addr, wdata, output rdata, ready);

endinterface

//--- cpu8_pkg.sv
/*
  shared widths, encodings and types of the 8-bit register machine
  word and address are both 8 bits; pc and registers hold the same words
  mem_wait must be 2 or more
  all compares are unsigned
*/
package cpu8_pkg;

  // --------------------------------------
  // widths and sizes
  localparam int word_bits  = 8;
  localparam int addr_bits  = 8;
  localparam int num_regs   = 4;
  localparam int reg_bits   = 2;
  localparam int entry_addr = 0;   // pc after reset
  localparam int mem_wait   = 2;   // req to ready, in cycles

  // special registers
  localparam int sp_idx     = 0;   // stack pointer
  localparam int status_idx = 3;   // compare flags land here

  // status bits from compare, 7:6 are zero
  localparam int st_eq = 5;
  localparam int st_ne = 4;
  localparam int st_lt = 3;
  localparam int st_le = 2;
  localparam int st_gt = 1;
  localparam int st_ge = 0;

  // --------------------------------------
  // 1-register sub-opcodes, bits 4:2
  // with immediate flag
  localparam logic [2:0] op1_ldi  = 3'b000;  // reg = imm
  localparam logic [2:0] op1_ld   = 3'b001;  // reg = mem[imm]
  localparam logic [2:0] op1_st   = 3'b010;  // mem[imm] = reg
  // without immediate flag
  localparam logic [2:0] op1_jmp  = 3'b001;
  localparam logic [2:0] op1_jrel = 3'b010;  // relative to next instr
  localparam logic [2:0] op1_call = 3'b011;
  localparam logic [2:0] op1_not  = 3'b100;
  localparam logic [2:0] op1_lnot = 3'b101;
  localparam logic [2:0] op1_push = 3'b110;
  localparam logic [2:0] op1_pop  = 3'b111;

  // 0-register opcodes, bits 5:0
  localparam logic [5:0] op0_halt = 6'd0;
  localparam logic [5:0] op0_nop  = 6'd1;
  localparam logic [5:0] op0_ret  = 6'd2;

  // --------------------------------------
  // types
  typedef logic [word_bits-1:0] word_t;
  typedef logic [addr_bits-1:0] addr_t;
  typedef logic [reg_bits-1:0]  reg_idx_t;

  // first eight follow opcode bits 6:4 of a 2-register instr
  typedef enum logic [3:0] {
    mov, add, sub, shl, shr, cmp, and_op, or_op,
    not_bit, not_log
  } alu_op_e;

  typedef enum logic [2:0] {
    fetch, decode, load_imm, exec, write_mem, halt
  } cycle_e;

endpackage
